// ==== rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // structure sizes
    localparam int iq_depth  = 4;
    localparam int rob_depth = 4;
    localparam int rs_depth  = 2;

    // names a pending result by its reorder buffer slot
    typedef logic [$clog2(rob_depth)-1:0] tag_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_none
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } i_type_t;

    // same word, two layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_t;

    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [6:0] funct7_sub = 7'b0100000;

endpackage

// ==== instruction_queue.sv ====
module instruction_queue import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    input  rv32i_word in_inst_i,
    output logic      in_ready_o,
    output logic      iq_valid_o,
    output rv32i_word iq_inst_o,
    input  logic      iq_shift_i
);

    rv32i_word                   mem [iq_depth];
    logic [$clog2(iq_depth)-1:0] head;
    logic [$clog2(iq_depth)-1:0] tail;
    logic [$clog2(iq_depth):0]   count;
    logic                        push;
    logic                        pop;

    assign in_ready_o = (count < iq_depth);
    assign iq_valid_o = (count != '0);
    assign iq_inst_o  = mem[head];

    assign push = in_valid_i && in_ready_o;
    assign pop  = iq_shift_i && iq_valid_o;

    // word storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= in_inst_i;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + ($clog2(iq_depth)+1)'(push) - ($clog2(iq_depth)+1)'(pop);
        end
    end

endmodule

// ==== rename_dispatch.sv ====
module rename_dispatch import rv32i_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        iq_valid_i,
    input  rv32i_word                   iq_inst_i,
    output logic                        iq_shift_o,
    input  logic                        rob_full_i,
    input  tag_t                        rob_tail_tag_i,
    input  logic [rob_depth-1:0]        rob_done_i,
    input  rv32i_word [rob_depth-1:0]   rob_value_i,
    output logic                        rob_alloc_o,
    output rv32i_reg                    rob_rd_o,
    input  logic                        rs_full_i,
    output logic                        rs_alloc_o,
    output alu_op_t                     rs_op_o,
    output tag_t                        rs_tag_o,
    output rv32i_word                   rs_vj_o,
    output rv32i_word                   rs_vk_o,
    output tag_t                        rs_qj_o,
    output tag_t                        rs_qk_o,
    output logic                        rs_qj_busy_o,
    output logic                        rs_qk_busy_o,
    input  logic                        cdb_valid_i,
    input  tag_t                        cdb_tag_i,
    input  rv32i_word                   cdb_value_i,
    input  logic                        wb_valid_i,
    input  rv32i_reg                    wb_rd_i,
    input  tag_t                        wb_tag_i,
    input  rv32i_word                   wb_value_i
);

    // tagged register file
    rv32i_word   rf_value [32];
    tag_t        rf_tag [32];
    logic [31:0] rf_busy;

    inst_t       inst;
    alu_op_t     op;
    logic        is_imm;
    rv32i_word   imm_ext;
    logic        dispatch;

    function automatic alu_op_t f3_to_op(input logic [2:0] f3);
        case (f3)
            f3_add:  return alu_add;
            f3_slt:  return alu_slt;
            f3_xor:  return alu_xor;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_none;
        endcase
    endfunction

    // register file, then a done ROB entry, then the bus, else wait on the tag
    function automatic void resolve(input rv32i_reg src, output rv32i_word val,
                                    output tag_t tag, output logic busy);
        tag_t t;
        t    = rf_tag[src];
        val  = '0;
        tag  = '0;
        busy = 1'b0;
        if (src != '0) begin
            if (!rf_busy[src]) begin
                val = rf_value[src];
            end else if (rob_done_i[t]) begin
                val = rob_value_i[t];
            end else if (cdb_valid_i && cdb_tag_i == t) begin
                val = cdb_value_i;
            end else begin
                busy = 1'b1;
                tag  = t;
            end
        end
    endfunction

    assign inst    = iq_inst_i;
    assign imm_ext = {{20{inst.i.imm[11]}}, inst.i.imm};

    always_comb begin
        op     = alu_none;
        is_imm = 1'b0;
        if (inst.r.opcode == op_reg) begin
            if (inst.r.funct7 == funct7_sub && inst.r.funct3 == f3_add) begin
                op = alu_sub;
            end else if (inst.r.funct7 == '0) begin
                op = f3_to_op(inst.r.funct3);
            end
        end else if (inst.i.opcode == op_imm) begin
            is_imm = 1'b1;
            op     = f3_to_op(inst.i.funct3);
        end
    end

    always_comb begin
        resolve(inst.r.rs1, rs_vj_o, rs_qj_o, rs_qj_busy_o);
        resolve(inst.r.rs2, rs_vk_o, rs_qk_o, rs_qk_busy_o);
        if (is_imm) begin
            rs_vk_o      = imm_ext;
            rs_qk_o      = '0;
            rs_qk_busy_o = 1'b0;
        end
        // unsupported words carry no operands and produce 0
        if (op == alu_none) begin
            rs_vj_o      = '0;
            rs_qj_o      = '0;
            rs_qj_busy_o = 1'b0;
            rs_vk_o      = '0;
            rs_qk_o      = '0;
            rs_qk_busy_o = 1'b0;
        end
    end

    assign dispatch    = iq_valid_i && !rob_full_i && !rs_full_i;
    assign iq_shift_o  = dispatch;
    assign rob_alloc_o = dispatch;
    assign rs_alloc_o  = dispatch;
    assign rs_op_o     = op;
    assign rs_tag_o    = rob_tail_tag_i;
    assign rob_rd_o    = (op == alu_none) ? '0 : inst.r.rd;

    // write-back first so a new tag on the same rd wins
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rf_busy <= '0;
            for (int r = 0; r < 32; r++) begin
                rf_value[r] <= '0;
            end
        end else begin
            if (wb_valid_i && wb_rd_i != '0) begin
                rf_value[wb_rd_i] <= wb_value_i;
                if (rf_tag[wb_rd_i] == wb_tag_i) begin
                    rf_busy[wb_rd_i] <= 1'b0;
                end
            end
            if (dispatch && rob_rd_o != '0) begin
                rf_busy[rob_rd_o] <= 1'b1;
                rf_tag[rob_rd_o]  <= rob_tail_tag_i;
            end
        end
    end

endmodule

// ==== alu_station.sv ====
module alu_station import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      rs_alloc_i,
    input  alu_op_t   rs_op_i,
    input  tag_t      rs_tag_i,
    input  rv32i_word rs_vj_i,
    input  rv32i_word rs_vk_i,
    input  tag_t      rs_qj_i,
    input  tag_t      rs_qk_i,
    input  logic      rs_qj_busy_i,
    input  logic      rs_qk_busy_i,
    output logic      rs_full_o,
    output logic      cdb_valid_o,
    output tag_t      cdb_tag_o,
    output rv32i_word cdb_value_o
);

    logic        valid [rs_depth];
    logic [1:0]  age [rs_depth];
    alu_op_t     op [rs_depth];
    tag_t        tag [rs_depth];
    rv32i_word   vj [rs_depth];
    rv32i_word   vk [rs_depth];
    tag_t        qj [rs_depth];
    tag_t        qk [rs_depth];
    logic        qj_busy [rs_depth];
    logic        qk_busy [rs_depth];
    int unsigned alloc_idx;
    int unsigned issue_idx;
    logic        issue;
    logic        hit_j;
    logic        hit_k;

    function automatic rv32i_word alu(input alu_op_t f, input rv32i_word a, input rv32i_word b);
        case (f)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_slt: return {31'b0, $signed(a) < $signed(b)};
            default: return '0;
        endcase
    endfunction

    // lowest free slot
    always_comb begin
        rs_full_o = 1'b1;
        alloc_idx = 0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                rs_full_o = 1'b0;
                alloc_idx = i;
            end
        end
    end

    // oldest entry with both operands in hand
    always_comb begin
        issue     = 1'b0;
        issue_idx = 0;
        for (int i = 0; i < rs_depth; i++) begin
            if (valid[i] && !qj_busy[i] && !qk_busy[i] &&
                (!issue || age[i] > age[issue_idx])) begin
                issue     = 1'b1;
                issue_idx = i;
            end
        end
    end

    // operands arriving on the bus while the entry is written
    assign hit_j = cdb_valid_o && cdb_tag_o == rs_qj_i;
    assign hit_k = cdb_valid_o && cdb_tag_o == rs_qk_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
            for (int i = 0; i < rs_depth; i++) begin
                valid[i] <= 1'b0;
            end
        end else begin
            cdb_valid_o <= issue;
            for (int i = 0; i < rs_depth; i++) begin
                if (valid[i] && qj_busy[i] && cdb_valid_o && cdb_tag_o == qj[i]) begin
                    vj[i]      <= cdb_value_o;
                    qj_busy[i] <= 1'b0;
                end
                if (valid[i] && qk_busy[i] && cdb_valid_o && cdb_tag_o == qk[i]) begin
                    vk[i]      <= cdb_value_o;
                    qk_busy[i] <= 1'b0;
                end
                if (rs_alloc_i && valid[i] && age[i] < 2'(rs_depth - 1)) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
            if (issue) begin
                valid[issue_idx] <= 1'b0;
            end
            if (rs_alloc_i) begin
                valid[alloc_idx]   <= 1'b1;
                age[alloc_idx]     <= '0;
                op[alloc_idx]      <= rs_op_i;
                tag[alloc_idx]     <= rs_tag_i;
                qj[alloc_idx]      <= rs_qj_i;
                qk[alloc_idx]      <= rs_qk_i;
                qj_busy[alloc_idx] <= rs_qj_busy_i && !hit_j;
                qk_busy[alloc_idx] <= rs_qk_busy_i && !hit_k;
                vj[alloc_idx]      <= (rs_qj_busy_i && hit_j) ? cdb_value_o : rs_vj_i;
                vk[alloc_idx]      <= (rs_qk_busy_i && hit_k) ? cdb_value_o : rs_vk_i;
            end
        end
    end

    // single-cycle ALU with its result registered onto the bus
    always_ff @(posedge clk) begin
        if (issue) begin
            cdb_tag_o   <= tag[issue_idx];
            cdb_value_o <= alu(op[issue_idx], vj[issue_idx], vk[issue_idx]);
        end
    end

endmodule

// ==== reorder_buffer.sv ====
module reorder_buffer import rv32i_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      rob_alloc_i,
    input  rv32i_reg                  rob_rd_i,
    output logic                      rob_full_o,
    output tag_t                      rob_tail_tag_o,
    output logic [rob_depth-1:0]      rob_done_o,
    output rv32i_word [rob_depth-1:0] rob_value_o,
    input  logic                      cdb_valid_i,
    input  tag_t                      cdb_tag_i,
    input  rv32i_word                 cdb_value_i,
    output logic                      commit_valid_o,
    output rv32i_reg                  commit_rd_o,
    output rv32i_word                 commit_value_o,
    input  logic                      commit_ready_i,
    output logic                      wb_valid_o,
    output rv32i_reg                  wb_rd_o,
    output tag_t                      wb_tag_o,
    output rv32i_word                 wb_value_o
);

    rv32i_reg                   rd_q [rob_depth];
    tag_t                       head;
    tag_t                       tail;
    logic [$clog2(rob_depth):0] count;
    logic                       commit_fire;

    assign rob_full_o     = (count == rob_depth);
    assign rob_tail_tag_o = tail;

    // head retires once its result is in
    assign commit_valid_o = (count != '0) && rob_done_o[head];
    assign commit_rd_o    = rd_q[head];
    assign commit_value_o = rob_value_o[head];
    assign commit_fire    = commit_valid_o && commit_ready_i;

    // write-back mirrors the commit transfer
    assign wb_valid_o = commit_fire;
    assign wb_rd_o    = rd_q[head];
    assign wb_tag_o   = head;
    assign wb_value_o = rob_value_o[head];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            rob_done_o <= '0;
        end else begin
            if (cdb_valid_i) begin
                rob_done_o[cdb_tag_i]  <= 1'b1;
                rob_value_o[cdb_tag_i] <= cdb_value_i;
            end
            if (commit_fire) begin
                rob_done_o[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            // a fresh entry starts not done
            if (rob_alloc_i) begin
                rob_done_o[tail] <= 1'b0;
                rd_q[tail]       <= rob_rd_i;
                tail             <= tail + 1'b1;
            end
            count <= count + ($clog2(rob_depth)+1)'(rob_alloc_i)
                           - ($clog2(rob_depth)+1)'(commit_fire);
        end
    end

endmodule

// ==== ooo_core.sv ====
module ooo_core import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    input  rv32i_word in_inst_i,
    output logic      in_ready_o,
    output logic      commit_valid_o,
    output rv32i_reg  commit_rd_o,
    output rv32i_word commit_value_o,
    input  logic      commit_ready_i
);

    logic                      iq_valid;
    rv32i_word                 iq_inst;
    logic                      iq_shift;
    logic                      rob_full;
    tag_t                      rob_tail_tag;
    logic [rob_depth-1:0]      rob_done;
    rv32i_word [rob_depth-1:0] rob_value;
    logic                      rob_alloc;
    rv32i_reg                  rob_rd;
    logic                      rs_full;
    logic                      rs_alloc;
    alu_op_t                   rs_op;
    tag_t                      rs_tag;
    rv32i_word                 rs_vj;
    rv32i_word                 rs_vk;
    tag_t                      rs_qj;
    tag_t                      rs_qk;
    logic                      rs_qj_busy;
    logic                      rs_qk_busy;
    logic                      cdb_valid;
    tag_t                      cdb_tag;
    rv32i_word                 cdb_value;
    logic                      wb_valid;
    rv32i_reg                  wb_rd;
    tag_t                      wb_tag;
    rv32i_word                 wb_value;

    instruction_queue instruction_queue_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .in_valid_i(in_valid_i),
        .in_inst_i(in_inst_i),
        .in_ready_o(in_ready_o),
        .iq_valid_o(iq_valid),
        .iq_inst_o(iq_inst),
        .iq_shift_i(iq_shift)
    );

    rename_dispatch rename_dispatch_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        // queue head
        .iq_valid_i(iq_valid),
        .iq_inst_i(iq_inst),
        .iq_shift_o(iq_shift),
        // reorder buffer allocation and lookup
        .rob_full_i(rob_full),
        .rob_tail_tag_i(rob_tail_tag),
        .rob_done_i(rob_done),
        .rob_value_i(rob_value),
        .rob_alloc_o(rob_alloc),
        .rob_rd_o(rob_rd),
        // station entry
        .rs_full_i(rs_full),
        .rs_alloc_o(rs_alloc),
        .rs_op_o(rs_op),
        .rs_tag_o(rs_tag),
        .rs_vj_o(rs_vj),
        .rs_vk_o(rs_vk),
        .rs_qj_o(rs_qj),
        .rs_qk_o(rs_qk),
        .rs_qj_busy_o(rs_qj_busy),
        .rs_qk_busy_o(rs_qk_busy),
        .cdb_valid_i(cdb_valid),
        .cdb_tag_i(cdb_tag),
        .cdb_value_i(cdb_value),
        // retirement
        .wb_valid_i(wb_valid),
        .wb_rd_i(wb_rd),
        .wb_tag_i(wb_tag),
        .wb_value_i(wb_value)
    );

    alu_station alu_station_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rs_alloc_i(rs_alloc),
        .rs_op_i(rs_op),
        .rs_tag_i(rs_tag),
        .rs_vj_i(rs_vj),
        .rs_vk_i(rs_vk),
        .rs_qj_i(rs_qj),
        .rs_qk_i(rs_qk),
        .rs_qj_busy_i(rs_qj_busy),
        .rs_qk_busy_i(rs_qk_busy),
        .rs_full_o(rs_full),
        .cdb_valid_o(cdb_valid),
        .cdb_tag_o(cdb_tag),
        .cdb_value_o(cdb_value)
    );

    reorder_buffer reorder_buffer_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rob_alloc_i(rob_alloc),
        .rob_rd_i(rob_rd),
        .rob_full_o(rob_full),
        .rob_tail_tag_o(rob_tail_tag),
        .rob_done_o(rob_done),
        .rob_value_o(rob_value),
        .cdb_valid_i(cdb_valid),
        .cdb_tag_i(cdb_tag),
        .cdb_value_i(cdb_value),
        .commit_valid_o(commit_valid_o),
        .commit_rd_o(commit_rd_o),
        .commit_value_o(commit_value_o),
        .commit_ready_i(commit_ready_i),
        .wb_valid_o(wb_valid),
        .wb_rd_o(wb_rd),
        .wb_tag_o(wb_tag),
        .wb_value_o(wb_value)
    );

endmodule

// ==== tb_ooo_core.sv ====
module tb_ooo_core import rv32i_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 400;

    logic      clk;
    logic      rst_n_i;
    logic      in_valid_i;
    rv32i_word in_inst_i;
    logic      in_ready_o;
    logic      commit_valid_o;
    rv32i_reg  commit_rd_o;
    rv32i_word commit_value_o;
    logic      commit_ready_i;

    // reference register file and expected commits in program order
    rv32i_word model_regs [32];
    rv32i_reg  exp_rd [$];
    rv32i_word exp_val [$];

    string  test_name = "reset";
    int     error_count = 0;
    int     commit_count = 0;
    // 0 ready high, 1 ready low, 2 random
    int     ready_mode = 0;
    integer seed = 32'h5c69;

    ooo_core ooo_core_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .in_valid_i(in_valid_i),
        .in_inst_i(in_inst_i),
        .in_ready_o(in_ready_o),
        .commit_valid_o(commit_valid_o),
        .commit_rd_o(commit_rd_o),
        .commit_value_o(commit_value_o),
        .commit_ready_i(commit_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic rv32i_word r_word(input logic [6:0] f7, input rv32i_reg rs2,
                                         input rv32i_reg rs1, input logic [2:0] f3,
                                         input rv32i_reg rd);
        inst_t d;
        d.r.funct7 = f7;
        d.r.rs2    = rs2;
        d.r.rs1    = rs1;
        d.r.funct3 = f3;
        d.r.rd     = rd;
        d.r.opcode = op_reg;
        return d;
    endfunction

    function automatic rv32i_word i_word(input logic [11:0] imm, input rv32i_reg rs1,
                                         input logic [2:0] f3, input rv32i_reg rd);
        inst_t d;
        d.i.imm    = imm;
        d.i.rs1    = rs1;
        d.i.funct3 = f3;
        d.i.rd     = rd;
        d.i.opcode = op_imm;
        return d;
    endfunction

    // shared by both layouts with add standing in for addi
    function automatic rv32i_word ref_result(input logic [2:0] f3, input rv32i_word a,
                                             input rv32i_word b, output logic known);
        known = 1'b1;
        case (f3)
            f3_add:  return a + b;
            f3_and:  return a & b;
            f3_or:   return a | b;
            f3_xor:  return a ^ b;
            f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: begin
                known = 1'b0;
                return '0;
            end
        endcase
    endfunction

    task automatic model_step(input rv32i_word w);
        inst_t     d;
        rv32i_word a;
        rv32i_word b;
        rv32i_word res;
        rv32i_reg  rd;
        logic      known;
        d     = w;
        a     = model_regs[d.r.rs1];
        b     = model_regs[d.r.rs2];
        rd    = d.r.rd;
        known = 1'b0;
        res   = '0;
        if (d.r.opcode == op_reg) begin
            if (d.r.funct7 == funct7_sub && d.r.funct3 == f3_add) begin
                res   = a - b;
                known = 1'b1;
            end else if (d.r.funct7 == 7'b0) begin
                res = ref_result(d.r.funct3, a, b, known);
            end
        end else if (d.i.opcode == op_imm) begin
            b   = {{20{d.i.imm[11]}}, d.i.imm};
            res = ref_result(d.i.funct3, a, b, known);
        end
        if (!known) begin
            rd  = '0;
            res = '0;
        end
        // x0 commits its value but is never written
        if (rd != '0) begin
            model_regs[rd] = res;
        end
        exp_rd.push_back(rd);
        exp_val.push_back(res);
    endtask

    task automatic check_commit();
        rv32i_reg  rd;
        rv32i_word val;
        commit_count++;
        if (exp_rd.size() == 0) begin
            $display("%s: commit of x%0d arrived with no instruction outstanding",
                     test_name, commit_rd_o);
            error_count++;
        end else begin
            rd  = exp_rd.pop_front();
            val = exp_val.pop_front();
            if (commit_rd_o != rd || commit_value_o != val) begin
                $display("CHECK FAILED %s: expected x%0d=%h, actual x%0d=%h",
                         test_name, rd, val, commit_rd_o, commit_value_o);
                error_count++;
            end
        end
    endtask

    // ready chosen at posedge, applied at negedge, commit seen before the next posedge
    initial begin : commit_monitor
        logic next_ready;
        int   rnd;
        commit_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            if (ready_mode == 0) begin
                next_ready = 1'b1;
            end else if (ready_mode == 1) begin
                next_ready = 1'b0;
            end else begin
                rnd        = $random(seed);
                next_ready = rnd[0];
            end
            @(negedge clk);
            commit_ready_i = next_ready;
            #1;
            if (commit_valid_o && commit_ready_i) begin
                check_commit();
            end
        end
    end

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic send_inst(input rv32i_word w);
        int waited;
        waited     = 0;
        in_valid_i = 1'b1;
        in_inst_i  = w;
        #1;
        while (!in_ready_o && waited < wait_limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!in_ready_o) begin
            $display("%s: instruction %h was never accepted", test_name, w);
            error_count++;
        end else begin
            model_step(w);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic send_r(input logic [6:0] f7, input logic [2:0] f3, input rv32i_reg rd,
                          input rv32i_reg rs1, input rv32i_reg rs2);
        send_inst(r_word(f7, rs2, rs1, f3, rd));
    endtask

    task automatic send_i(input logic [2:0] f3, input rv32i_reg rd, input rv32i_reg rs1,
                          input logic [11:0] imm);
        send_inst(i_word(imm, rs1, f3, rd));
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_rd.size() != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd.size() != 0) begin
            $display("%s: %0d instructions never committed", test_name, exp_rd.size());
            error_count++;
        end
    endtask

    task automatic independent_ops();
        test_name = "independent_ops";
        send_i(f3_add, 1, 0, 12'd100);
        send_i(f3_add, 2, 0, 12'hff9);
        send_i(f3_add, 3, 0, 12'h035);
        send_r(7'b0, f3_add, 4, 1, 2);
        send_r(funct7_sub, f3_add, 5, 1, 2);
        send_r(7'b0, f3_and, 6, 1, 3);
        send_r(7'b0, f3_or, 7, 1, 3);
        send_r(7'b0, f3_xor, 8, 1, 3);
        send_r(7'b0, f3_slt, 9, 2, 1);
        send_i(f3_and, 10, 1, 12'h0f0);
        send_i(f3_or, 11, 2, 12'h123);
        send_i(f3_xor, 12, 3, 12'hfff);
        send_i(f3_slt, 13, 2, 12'd5);
        wait_drain();
    endtask

    task automatic dependency_chain();
        test_name = "dependency_chain";
        // back to back so operands come off the bus
        send_i(f3_add, 1, 0, 12'd5);
        send_r(7'b0, f3_add, 2, 1, 1);
        send_r(funct7_sub, f3_add, 3, 2, 1);
        send_r(7'b0, f3_add, 4, 3, 2);
        send_r(funct7_sub, f3_add, 5, 4, 1);
        send_r(7'b0, f3_add, 1, 5, 4);
        wait_drain();
        // held commits leave x6 and x7 done in the ROB
        ready_mode = 1;
        send_i(f3_add, 6, 1, 12'h7ff);
        send_r(7'b0, f3_add, 7, 6, 6);
        idle(6);
        send_r(funct7_sub, f3_add, 8, 7, 6);
        ready_mode = 0;
        wait_drain();
        // everything retired so operands come from the register file
        send_r(7'b0, f3_add, 9, 8, 4);
        wait_drain();
    endtask

    task automatic zero_register();
        test_name = "zero_register";
        send_i(f3_add, 0, 0, 12'd42);
        send_r(7'b0, f3_add, 14, 0, 0);
        send_r(7'b0, f3_add, 15, 0, 1);
        wait_drain();
    endtask

    task automatic commit_backpressure();
        int waited;
        test_name  = "commit_backpressure";
        ready_mode = 1;
        for (int k = 0; k < 8; k++) begin
            send_i(f3_add, rv32i_reg'(16 + k), (k == 0) ? rv32i_reg'(1) : rv32i_reg'(15 + k),
                   12'(3 * k + 1));
        end
        waited = 0;
        while (in_ready_o && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready_o) begin
            $display("%s: in_ready_o stayed high while commits were held", test_name);
            error_count++;
        end
        ready_mode = 0;
        wait_drain();
    endtask

    function automatic rv32i_word random_inst(input int kind, input int rnd);
        rv32i_reg    rd;
        rv32i_reg    rs1;
        rv32i_reg    rs2;
        logic [11:0] imm;
        rd  = rv32i_reg'(rnd[2:0]);
        rs1 = rv32i_reg'(rnd[5:3]);
        rs2 = rv32i_reg'(rnd[8:6]);
        imm = rnd[20:9];
        case (kind)
            0:       return r_word(7'b0, rs2, rs1, f3_add, rd);
            1:       return r_word(funct7_sub, rs2, rs1, f3_add, rd);
            2:       return r_word(7'b0, rs2, rs1, f3_and, rd);
            3:       return r_word(7'b0, rs2, rs1, f3_or, rd);
            4:       return r_word(7'b0, rs2, rs1, f3_xor, rd);
            5:       return r_word(7'b0, rs2, rs1, f3_slt, rd);
            6:       return i_word(imm, rs1, f3_add, rd);
            7:       return i_word(imm, rs1, f3_and, rd);
            8:       return i_word(imm, rs1, f3_or, rd);
            9:       return i_word(imm, rs1, f3_xor, rd);
            default: return i_word(imm, rs1, f3_slt, rd);
        endcase
    endfunction

    task automatic random_stream();
        rv32i_word stream [60];
        int        kind;
        int        rnd;
        int        start;
        test_name = "random_stream";
        // drawn up front so the monitor alone uses the seed while streaming
        for (int n = 0; n < 60; n++) begin
            kind      = {$random(seed)} % 11;
            rnd       = $random(seed);
            stream[n] = random_inst(kind, rnd);
        end
        start      = commit_count;
        ready_mode = 2;
        for (int n = 0; n < 60; n++) begin
            send_inst(stream[n]);
        end
        wait_drain();
        ready_mode = 0;
        if (commit_count - start != 60) begin
            $display("CHECK FAILED %s: expected %0d commits, actual %0d",
                     test_name, 60, commit_count - start);
            error_count++;
        end
    endtask

    initial begin
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_inst_i  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        if (commit_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
            $display("after reset the core is not idle and ready");
            error_count++;
        end
        independent_ops();
        dependency_chain();
        zero_register();
        commit_backpressure();
        random_stream();
        idle(4);
        $display("errors: %0d, commits: %0d", error_count, commit_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== ooo_core.f ====
rv32i_pkg.sv
instruction_queue.sv
rename_dispatch.sv
alu_station.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_ooo_core -f ooo_core.f -o tb_ooo_core
	./obj_dir/tb_ooo_core | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
